//--- filelist.f
+incdir+hdl
hdl/sprite_pkg.sv
hdl/pixel_if.sv
hdl/color_palette.sv
hdl/vga_timing.sv
hdl/sprite_regs.sv
hdl/sprite_renderer.sv
hdl/sprite_display.sv
tests/clock_gen.sv
tests/sprite_display_tb.sv

//--- hdl/color_palette.sv
`default_nettype none
`timescale 1ns/100ps

module color_palette (
    input  logic                   clk,
    input  sprite_pkg::color_idx_t index,
    output sprite_pkg::rgb_t       color
);

    localparam int CUBE  = 6;
    localparam int STEP  = 51;  // 255 / 5
    localparam int LIMIT = CUBE * CUBE * CUBE;

    logic [2:0] r_lvl;
    logic [2:0] g_lvl;
    logic [2:0] b_lvl;

    // cube coordinates of the index
    assign r_lvl = 3'(index / (CUBE * CUBE));
    assign g_lvl = 3'((index / CUBE) % CUBE);
    assign b_lvl = 3'(index % CUBE);

    always_ff @(posedge clk) begin
        if (index < LIMIT) begin
            color.red   <= 8'(STEP * r_lvl);
            color.green <= 8'(STEP * g_lvl);
            color.blue  <= 8'(STEP * b_lvl);
        end else begin
            color <= '0;  // upper 40 entries
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixel_if.sv
`default_nettype none
`timescale 1ns/100ps

interface pixel_if;

    sprite_pkg::coord_t hcount;
    sprite_pkg::coord_t vcount;
    logic               hsync_n;
    logic               vsync_n;
    logic               blank_n;

    modport source (
        output hcount,
        output vcount,
        output hsync_n,
        output vsync_n,
        output blank_n
    );

    modport sink (
        input  hcount,
        input  vcount,
        input  hsync_n,
        input  vsync_n,
        input  blank_n
    );

endinterface

`default_nettype wire

//--- hdl/sprite_config.svh
`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// horizontal timing, in clk cycles (two per pixel)
`define H_ACTIVE        1280
`define H_FRONT         32
`define H_SYNC          192
`define H_BACK          96
`define H_TOTAL         (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing, in lines
`define V_ACTIVE        480
`define V_FRONT         10
`define V_SYNC          2
`define V_BACK          33
`define V_TOTAL         (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define NUM_OBJECTS     8
`define NUM_SPRITES     4
`define SPRITE_DIM      16

// word addresses on the write port
`define ADDR_BG         0
`define ADDR_OBJ_BASE   1
`define ADDR_PAT_BASE   256

`define BG_RESET        24'h008000

`define RENDER_LATENCY  3

`endif

//--- hdl/sprite_display.sv
`default_nettype none
`timescale 1ns/100ps

module sprite_display (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [9:0]  address,
    input  logic [31:0] writedata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        vga_sync_n
);

    sprite_pkg::obj_table_t objects;
    sprite_pkg::rgb_t       background;
    sprite_pkg::rgb_t       rgb;
    logic                   pat_we;
    sprite_pkg::pat_addr_t  pat_addr;
    logic [31:0]            pat_data;

    pixel_if pix ();

    vga_timing u_timing (
        .clk     (clk),
        .reset   (reset),
        .pix     (pix),
        .vga_clk (vga_clk)
    );

    sprite_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .objects    (objects),
        .background (background),
        .pat_we     (pat_we),
        .pat_addr   (pat_addr),
        .pat_data   (pat_data)
    );

    sprite_renderer u_renderer (
        .clk        (clk),
        .reset      (reset),
        .pix        (pix),
        .objects    (objects),
        .background (background),
        .pat_we     (pat_we),
        .pat_addr   (pat_addr),
        .pat_data   (pat_data),
        .rgb        (rgb),
        .hsync_n    (vga_hs),
        .vsync_n    (vga_vs),
        .blank_n    (vga_blank_n)
    );

    assign vga_r = rgb.red;
    assign vga_g = rgb.green;
    assign vga_b = rgb.blue;

    assign vga_sync_n = 1'b0;  // no sync on green

endmodule

`default_nettype wire

//--- hdl/sprite_pkg.sv
`default_nettype none

`include "sprite_config.svh"

package sprite_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef logic [7:0] color_idx_t;

    typedef logic [11:0] coord_t;

    // same bit order as the object write word, bits 31:1
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [5:0] sprite;
        logic       active;
    } obj_t;

    typedef obj_t [`NUM_OBJECTS-1:0] obj_table_t;

    // 32-bit pattern word, 4 pixels, lowest byte first
    typedef logic [7:0] pat_addr_t;

endpackage

`default_nettype wire

//--- hdl/sprite_regs.sv
`default_nettype none
`timescale 1ns/100ps

`include "sprite_config.svh"

module sprite_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   chipselect,
    input  logic                   write,
    input  logic [9:0]             address,
    input  logic [31:0]            writedata,
    output sprite_pkg::obj_table_t objects,
    output sprite_pkg::rgb_t       background,
    output logic                   pat_we,
    output sprite_pkg::pat_addr_t  pat_addr,
    output logic [31:0]            pat_data
);

    localparam int OBJ_W     = $clog2(`NUM_OBJECTS);
    localparam int PAT_SPACE = 2 ** $bits(sprite_pkg::pat_addr_t);

    logic       wr_en;
    logic       obj_sel;
    logic       pat_sel;
    logic [9:0] obj_off;
    logic [9:0] pat_off;

    assign wr_en   = chipselect && write;
    assign obj_off = address - 10'(`ADDR_OBJ_BASE);
    assign pat_off = address - 10'(`ADDR_PAT_BASE);

    assign obj_sel = address >= `ADDR_OBJ_BASE && obj_off < `NUM_OBJECTS;
    assign pat_sel = address >= `ADDR_PAT_BASE && pat_off < PAT_SPACE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            background <= `BG_RESET;
            objects    <= '0;  // all inactive
        end else if (wr_en) begin
            if (address == `ADDR_BG) begin
                background <= writedata[23:0];
            end else if (obj_sel) begin
                objects[obj_off[OBJ_W-1:0]].x      <= writedata[31:20];
                objects[obj_off[OBJ_W-1:0]].y      <= writedata[19:8];
                objects[obj_off[OBJ_W-1:0]].sprite <= writedata[7:2];
                objects[obj_off[OBJ_W-1:0]].active <= writedata[1];
                // bit 0 unused
            end
        end
    end

    // pattern words go straight to the renderer memory
    assign pat_we   = wr_en && pat_sel;
    assign pat_addr = sprite_pkg::pat_addr_t'(pat_off);
    assign pat_data = writedata;

    // software must not address objects past the table
    obj_index_in_range: assert property (
        @(posedge clk) disable iff (reset)
        wr_en && address >= `ADDR_OBJ_BASE && address < `ADDR_PAT_BASE
            |-> obj_off < `NUM_OBJECTS
    );

endmodule

`default_nettype wire

//--- hdl/sprite_renderer.sv
`default_nettype none
`timescale 1ns/100ps

`include "sprite_config.svh"

module sprite_renderer (
    input  logic                   clk,
    input  logic                   reset,
    pixel_if.sink                  pix,
    input  sprite_pkg::obj_table_t objects,
    input  sprite_pkg::rgb_t       background,
    input  logic                   pat_we,
    input  sprite_pkg::pat_addr_t  pat_addr,
    input  logic [31:0]            pat_data,
    output sprite_pkg::rgb_t       rgb,
    output logic                   hsync_n,
    output logic                   vsync_n,
    output logic                   blank_n
);

    localparam int PAT_WORDS = `NUM_SPRITES * `SPRITE_DIM * `SPRITE_DIM / 4;
    localparam int SPR_W     = $clog2(`NUM_SPRITES);
    localparam int DIM_W     = $clog2(`SPRITE_DIM);
    localparam int BYTE_W    = SPR_W + 2 * DIM_W;

    sprite_pkg::coord_t     px;
    logic                   hit;
    logic [BYTE_W-1:0]      byte_addr;
    logic                   s1_hit;
    logic [BYTE_W-1:0]      s1_addr;
    sprite_pkg::rgb_t       s1_bg;
    logic                   s2_hit;
    sprite_pkg::color_idx_t s2_index;
    sprite_pkg::rgb_t       s2_bg;
    logic                   s3_hit;
    sprite_pkg::rgb_t       s3_bg;
    sprite_pkg::rgb_t       pal_color;
    logic [2:0]             hs_d;  // one bit per stage
    logic [2:0]             vs_d;
    logic [2:0]             bl_d;
    logic [31:0]            pat_mem [PAT_WORDS];

    assign px = {1'b0, pix.hcount[11:1]};

    // stage 1 hit search, highest object wins
    always_comb begin
        logic [12:0] dx;
        logic [12:0] dy;
        hit       = 1'b0;
        byte_addr = '0;
        for (int i = `NUM_OBJECTS - 1; i >= 0; i--) begin
            dx = {1'b0, px} - {1'b0, objects[i].x};         // wraps high when left of box
            dy = {1'b0, pix.vcount} - {1'b0, objects[i].y};
            if (!hit && objects[i].active && dx < `SPRITE_DIM && dy < `SPRITE_DIM) begin
                hit = 1'b1;
                // sprite * 256 + ry * 16 + rx
                byte_addr = {objects[i].sprite[SPR_W-1:0], dy[DIM_W-1:0], dx[DIM_W-1:0]};
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_hit <= 1'b0;
            s2_hit <= 1'b0;
            s3_hit <= 1'b0;
            hs_d   <= '1;
            vs_d   <= '1;
            bl_d   <= '1;
        end else begin
            s1_hit <= hit;
            s2_hit <= s1_hit;
            s3_hit <= s2_hit;
            hs_d   <= {hs_d[1:0], pix.hsync_n};
            vs_d   <= {vs_d[1:0], pix.vsync_n};
            bl_d   <= {bl_d[1:0], pix.blank_n};
        end
    end

    // stage 2 pattern read, byte picked out of the word
    always_ff @(posedge clk) begin
        s1_addr  <= byte_addr;
        s1_bg    <= background;
        s2_index <= pat_mem[s1_addr[BYTE_W-1:2]][8*s1_addr[1:0] +: 8];
        s2_bg    <= s1_bg;
        s3_bg    <= s2_bg;
        if (pat_we) begin
            pat_mem[pat_addr] <= pat_data;
        end
    end

    color_palette u_palette (
        .clk   (clk),
        .index (s2_index),
        .color (pal_color)
    );

    // black means transparent
    assign rgb = (s3_hit && pal_color != '0) ? pal_color : s3_bg;

    assign hsync_n = hs_d[2];
    assign vsync_n = vs_d[2];
    assign blank_n = bl_d[2];

    pat_addr_in_memory: assert property (
        @(posedge clk) disable iff (reset)
        pat_we |-> pat_addr < PAT_WORDS
    );

endmodule

`default_nettype wire

//--- hdl/vga_timing.sv
`default_nettype none
`timescale 1ns/100ps

`include "sprite_config.svh"

module vga_timing (
    input  logic   clk,
    input  logic   reset,
    pixel_if.source pix,
    output logic   vga_clk
);

    sprite_pkg::coord_t hcount;
    sprite_pkg::coord_t vcount;
    logic               end_of_line;
    logic               end_of_field;

    assign end_of_line  = hcount == `H_TOTAL - 1;
    assign end_of_field = vcount == `V_TOTAL - 1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            if (end_of_field) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign pix.hcount = hcount;
    assign pix.vcount = vcount;

    // sync pulses after the front porch
    assign pix.hsync_n = !(hcount >= `H_ACTIVE + `H_FRONT &&
                           hcount < `H_ACTIVE + `H_FRONT + `H_SYNC);
    assign pix.vsync_n = !(vcount >= `V_ACTIVE + `V_FRONT &&
                           vcount < `V_ACTIVE + `V_FRONT + `V_SYNC);

    assign pix.blank_n = hcount < `H_ACTIVE && vcount < `V_ACTIVE;

    assign vga_clk = hcount[0];  // pixel clock, half of clk

    hcount_in_range: assert property (
        @(posedge clk) disable iff (reset)
        hcount < `H_TOTAL
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the sprite display testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module sprite_display_tb -f filelist.f -o sim_sprite

./obj_dir/sim_sprite | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tests/clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // released on a falling edge, after 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/sprite_display_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "sprite_config.svh"

module sprite_display_tb;

    localparam int          FRAME   = `H_TOTAL * `V_TOTAL;
    localparam int          TIMEOUT = 3 * FRAME;
    localparam logic [23:0] BG_NEW  = 24'h203040;

    typedef struct packed {
        logic [3:0]  test;
        logic [11:0] x;
        logic [11:0] y;
        logic [23:0] rgb;
    } pixel_check_t;

    logic         clk;
    logic         reset;
    logic         chipselect;
    logic         write;
    logic [9:0]   address;
    logic [31:0]  writedata;
    logic [7:0]   vga_r;
    logic [7:0]   vga_g;
    logic [7:0]   vga_b;
    logic         vga_clk;
    logic         vga_hs;
    logic         vga_vs;
    logic         vga_blank_n;
    logic         vga_sync_n;
    int           cyc;
    int           checks;
    int           errors;
    int           remaining [1:6];
    int           test_checks [1:6];
    int           test_errs [1:6];
    string        test_name [1:6];
    pixel_check_t table_q [$];

    clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    sprite_display UUT (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    // own copy of the raster, cycle k has hcount k mod line length
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic add_check(input int test, input int x, input int y, input logic [23:0] rgb);
        pixel_check_t entry;
        entry.test = 4'(test);
        entry.x    = 12'(x);
        entry.y    = 12'(y);
        entry.rgb  = rgb;
        table_q.push_back(entry);
        remaining[test]++;
    endtask

    // sorted by frame, then raster order
    task automatic build_table();
        add_check(1, 0, 10, 24'h008000);
        add_check(1, 320, 240, 24'h008000);
        add_check(1, 639, 479, 24'h008000);
        add_check(2, 0, 0, BG_NEW);
        add_check(6, 104, 49, BG_NEW);       // row above object 2
        add_check(3, 100, 50, 24'h3300cc);   // index 40
        add_check(3, 105, 52, 24'h6600ff);   // index 77
        add_check(6, 116, 55, BG_NEW);       // x + 16
        add_check(3, 115, 57, 24'hcc99ff);   // index 167
        add_check(3, 110, 60, 24'hffff00);   // index 210
        add_check(4, 104, 61, BG_NEW);       // index 220
        add_check(4, 108, 63, BG_NEW);       // index 0
        add_check(3, 103, 65, 24'h00cc99);   // index 27
        add_check(5, 201, 151, 24'h66cc33);  // object 3 alone
        add_check(5, 210, 156, 24'hcc33cc);
        add_check(5, 208, 161, BG_NEW);      // object 6 black over object 3
        add_check(5, 215, 165, 24'h3333ff);
        add_check(6, 300, 200, BG_NEW);      // inactive object 5
        add_check(6, 308, 210, BG_NEW);
        add_check(2, 320, 240, BG_NEW);
        add_check(2, 639, 479, BG_NEW);
    endtask

    task automatic wait_cycle(input int target);
        while (cyc < target) begin
            @(negedge clk);
        end
    endtask

    // call on a falling edge, returns on the next one
    task automatic bus_write(input logic [9:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(negedge clk);
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    function automatic logic [31:0] obj_word(input int x, input int y, input int spr,
                                             input bit active);
        return {12'(x), 12'(y), 6'(spr), active, 1'b0};
    endfunction

    // pixel index is 16 * ry + rx + 40 * sprite, mod 256
    function automatic logic [31:0] pattern_word(input int w);
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            word[8*b +: 8] = 8'(4 * w + b + 40 * (w / 64));
        end
        return word;
    endfunction

    task automatic load_scene();
        bus_write(10'(`ADDR_BG), {8'h00, BG_NEW});
        for (int w = 0; w < 256; w++) begin
            bus_write(10'(`ADDR_PAT_BASE + w), pattern_word(w));
        end
        bus_write(10'(`ADDR_OBJ_BASE + 2), obj_word(100, 50, 1, 1'b1));
        bus_write(10'(`ADDR_OBJ_BASE + 3), obj_word(200, 150, 2, 1'b1));
        bus_write(10'(`ADDR_OBJ_BASE + 6), obj_word(208, 154, 3, 1'b1));
        bus_write(10'(`ADDR_OBJ_BASE + 5), obj_word(300, 200, 1, 1'b0));
    endtask

    task automatic count_result(input int t, input bit ok);
        checks++;
        test_checks[t]++;
        if (!ok) begin
            errors++;
            test_errs[t]++;
        end
        remaining[t]--;
        if (remaining[t] == 0) begin
            $display("test %0d %s: %0d checks, %0d errors",
                     t, test_name[t], test_checks[t], test_errs[t]);
        end
    endtask

    initial begin
        pixel_check_t e;
        int           hs_low;
        int           bl_low;
        int           clk_err;
        int           vs_bad;
        int           row;
        int           target;
        bit           loaded;
        bit           ok;
        logic [23:0]  got;

        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        checks     = 0;
        errors     = 0;
        loaded     = 1'b0;
        test_name  = '{"reset state", "background", "sprite drawing", "transparency",
                       "priority", "inactive and outside"};
        foreach (remaining[t]) begin
            remaining[t]   = 0;
            test_checks[t] = 0;
            test_errs[t]   = 0;
        end
        build_table();
        remaining[1] += 2;  // sync line and vsync

        @(negedge reset);

        // one whole line of hsync and blank, lagged like the pixels
        wait_cycle(`H_TOTAL + `RENDER_LATENCY);
        hs_low  = 0;
        bl_low  = 0;
        clk_err = 0;
        repeat (`H_TOTAL) begin
            if (!vga_hs) hs_low++;
            if (!vga_blank_n) bl_low++;
            if (vga_clk !== cyc[0] || vga_sync_n !== 1'b0) clk_err++;  // clock not lagged
            @(negedge clk);
        end
        ok = hs_low == 192 && bl_low == 320 && clk_err == 0;
        assert (ok) else $display("FAIL %0t: hsync low %0d, blank low %0d, clock errors %0d",
                                  $time, hs_low, bl_low, clk_err);
        count_result(1, ok);

        foreach (table_q[i]) begin
            e = table_q[i];
            if (e.test != 1 && !loaded) begin
                wait_cycle((`V_ACTIVE + 1) * `H_TOTAL);  // vertical blanking of frame 0
                load_scene();
                loaded = 1'b1;

                // vsync of frame 0, low on lines 490 and 491 only
                wait_cycle(489 * `H_TOTAL + `RENDER_LATENCY);
                vs_bad = 0;
                repeat (4 * `H_TOTAL) begin
                    row = (cyc - `RENDER_LATENCY) / `H_TOTAL;
                    if (vga_vs !== !(row == 490 || row == 491)) vs_bad++;
                    @(negedge clk);
                end
                ok = vs_bad == 0;
                assert (ok) else $display("FAIL %0t: vsync wrong for %0d cycles near line 490",
                                          $time, vs_bad);
                count_result(1, ok);
            end
            target = (e.test == 1 ? 0 : FRAME) + int'(e.y) * `H_TOTAL + 2 * int'(e.x)
                     + `RENDER_LATENCY;
            ok = cyc <= target;
            assert (ok) else $display("table entry %0d comes after the raster has passed it", i);
            if (ok) begin
                wait_cycle(target);
                got = {vga_r, vga_g, vga_b};
                ok  = got === e.rgb;
                assert (ok) else $display("FAIL %0t: test %0d pixel (%0d,%0d) got %06h expected %06h",
                                          $time, e.test, e.x, e.y, got, e.rgb);
            end
            count_result(int'(e.test), ok);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        while (cyc < TIMEOUT) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
